/* fetch_unit.f */
+incdir+logic
logic/mem_pkg.sv
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/icache.sv
logic/stage_fetch.sv
tb/tb_fetch_memory.sv
tb/stage_fetch_assert.sv
tb/tb_stage_fetch.sv

/* logic/branch_predictor.sv */
`include "fetch_config.svh"

module branch_predictor (
    input  logic                                       clock,
    input  logic                                       reset,
    input  mem_pkg::addr_t                             pc_start,
    input  fetch_pkg::rob_resolve_t [`FETCH_WIDTH-1:0] rob_resolve,
    output fetch_pkg::pc_entry_t    [`FETCH_WIDTH-1:0] target_pc
);

    localparam int INDEX_BITS = $clog2(`BTB_SIZE);
    localparam int TAG_BITS   = 32 - 2 - INDEX_BITS;

    logic [`BTB_SIZE-1:0]  btb_valid;
    logic [`BTB_SIZE-1:0]  btb_valid_next;
    logic [TAG_BITS-1:0]   btb_tag [`BTB_SIZE];
    logic [TAG_BITS-1:0]   btb_tag_next [`BTB_SIZE];
    mem_pkg::addr_t        btb_target [`BTB_SIZE];
    mem_pkg::addr_t        btb_target_next [`BTB_SIZE];
    fetch_pkg::pht_state_e pht [`BTB_SIZE];
    fetch_pkg::pht_state_e pht_next [`BTB_SIZE];

    // lane source addresses plus the final prediction
    mem_pkg::addr_t [`FETCH_WIDTH:0] lane_pc;
    logic [`FETCH_WIDTH-1:0]         lane_hit;

    function automatic logic [INDEX_BITS-1:0] btb_index(input mem_pkg::addr_t pc);
        return pc[2 +: INDEX_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] btb_tag_of(input mem_pkg::addr_t pc);
        return pc[31 -: TAG_BITS];
    endfunction

    function automatic fetch_pkg::pht_state_e count_up(input fetch_pkg::pht_state_e state);
        case (state)
            fetch_pkg::STRONG_NT: return fetch_pkg::WEAK_NT;
            fetch_pkg::WEAK_NT:   return fetch_pkg::WEAK_T;
            default:              return fetch_pkg::STRONG_T;
        endcase
    endfunction

    function automatic fetch_pkg::pht_state_e count_down(input fetch_pkg::pht_state_e state);
        case (state)
            fetch_pkg::STRONG_T: return fetch_pkg::WEAK_T;
            fetch_pkg::WEAK_T:   return fetch_pkg::WEAK_NT;
            default:             return fetch_pkg::STRONG_NT;
        endcase
    endfunction

    // each lane looks up where the previous one points
    always_comb begin
        lane_pc[0] = pc_start;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lane_hit[i] = btb_valid[btb_index(lane_pc[i])]
                && (btb_tag[btb_index(lane_pc[i])] == btb_tag_of(lane_pc[i]))
                && (pht[btb_index(lane_pc[i])] inside {fetch_pkg::WEAK_T, fetch_pkg::STRONG_T});
            lane_pc[i+1] = lane_hit[i] ? btb_target[btb_index(lane_pc[i])] : lane_pc[i] + 32'd4;
            // misaligned source address gives no usable lane
            target_pc[i].valid = (lane_pc[i][1:0] == 2'b00);
            target_pc[i].pc    = lane_pc[i+1];
            target_pc[i].taken = lane_hit[i];
        end
    end

    // later resolve lanes see the updates of earlier ones
    always_comb begin
        btb_valid_next  = btb_valid;
        btb_tag_next    = btb_tag;
        btb_target_next = btb_target;
        pht_next        = pht;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (rob_resolve[i].valid) begin
                if (rob_resolve[i].taken) begin
                    pht_next[btb_index(rob_resolve[i].pc)] =
                        count_up(pht_next[btb_index(rob_resolve[i].pc)]);
                    btb_valid_next[btb_index(rob_resolve[i].pc)]  = 1'b1;
                    btb_tag_next[btb_index(rob_resolve[i].pc)]    = btb_tag_of(rob_resolve[i].pc);
                    btb_target_next[btb_index(rob_resolve[i].pc)] = rob_resolve[i].resolve_target;
                end else begin
                    pht_next[btb_index(rob_resolve[i].pc)] =
                        count_down(pht_next[btb_index(rob_resolve[i].pc)]);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
            for (int i = 0; i < `BTB_SIZE; i++) begin
                pht[i] <= fetch_pkg::WEAK_NT;
            end
        end else begin
            btb_valid <= btb_valid_next;
            pht       <= pht_next;
        end
    end

    // btb tag and target storage
    always_ff @(posedge clock) begin
        btb_tag    <= btb_tag_next;
        btb_target <= btb_target_next;
    end

endmodule

/* logic/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instructions fetched per cycle
`define FETCH_WIDTH 2

// btb and counter entries, indexed by pc bits 5..2
`define BTB_SIZE 16

// one 64-bit block per line, indexed by pc bits 7..3
`define ICACHE_LINES 32

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // two-bit pattern counter
    typedef enum logic [1:0] {
        STRONG_NT,
        WEAK_NT,
        WEAK_T,
        STRONG_T
    } pht_state_e;

    typedef logic [31:0] inst_t;

    // predictor result for one lane
    typedef struct packed {
        logic           valid;
        // predicted next address
        mem_pkg::addr_t pc;
        logic           taken;
    } pc_entry_t;

    // one instruction handed to decode
    typedef struct packed {
        logic           valid;
        inst_t          inst;
        mem_pkg::addr_t pc;
        mem_pkg::addr_t npc;
        logic           predict_taken;
        mem_pkg::addr_t predict_target;
    } if_id_packet_t;

    // control-flow outcome reported by the reorder buffer
    typedef struct packed {
        logic           valid;
        mem_pkg::addr_t pc;
        logic           taken;
        mem_pkg::addr_t resolve_target;
        // low when the prediction was wrong
        logic           success;
    } rob_resolve_t;

endpackage

/* logic/icache.sv */
`include "fetch_config.svh"

module icache (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      squash,
    input  logic                                      dcache_request,
    input  mem_pkg::mem_tag_t                         mem2proc_transaction_tag,
    input  mem_pkg::mem_tag_t                         mem2proc_data_tag,
    input  mem_pkg::mem_block_t                       mem2proc_data,
    input  mem_pkg::addr_t      [`FETCH_WIDTH-1:0]    icache_addr,
    input  logic                [`FETCH_WIDTH-1:0]    icache_request,
    output mem_pkg::mem_command_e                     proc2mem_command,
    output mem_pkg::addr_t                            proc2mem_addr,
    output mem_pkg::mem_block_t [`FETCH_WIDTH-1:0]    icache_data,
    output logic                [`FETCH_WIDTH-1:0]    icache_hit
);

    localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS   = 32 - 3 - INDEX_BITS;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REQUEST,
        MISS_WAIT
    } miss_state_e;

    // line storage
    mem_pkg::mem_block_t     line_data [`ICACHE_LINES];
    logic [TAG_BITS-1:0]     line_tag [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    // the single outstanding miss
    miss_state_e       miss_state;
    miss_state_e       miss_state_next;
    mem_pkg::addr_t    miss_addr;
    mem_pkg::mem_tag_t miss_tag;

    logic                  any_miss;
    mem_pkg::addr_t        first_miss_addr;
    logic                  load_accepted;
    logic                  fill;
    logic [INDEX_BITS-1:0] fill_index;

    // per-lane lookup
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            icache_data[i] = line_data[icache_addr[i][3 +: INDEX_BITS]];
            icache_hit[i]  = icache_request[i]
                && line_valid[icache_addr[i][3 +: INDEX_BITS]]
                && (line_tag[icache_addr[i][3 +: INDEX_BITS]] == icache_addr[i][31 -: TAG_BITS]);
        end
    end

    // lowest requested lane that misses
    always_comb begin
        any_miss        = 1'b0;
        first_miss_addr = icache_addr[0];
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (icache_request[i] && !icache_hit[i]) begin
                any_miss        = 1'b1;
                first_miss_addr = icache_addr[i];
            end
        end
    end

    // bus request, held off while the data cache owns the bus
    always_comb begin
        if (miss_state == MISS_REQUEST && !dcache_request) begin
            proc2mem_command = mem_pkg::MEM_LOAD;
        end else begin
            proc2mem_command = mem_pkg::MEM_NONE;
        end
        proc2mem_addr = {miss_addr[31:3], 3'b000};
    end

    // zero tag back from memory means refused, try again
    assign load_accepted = (proc2mem_command == mem_pkg::MEM_LOAD)
        && (mem2proc_transaction_tag != '0);

    assign fill       = (miss_state == MISS_WAIT) && (mem2proc_data_tag == miss_tag) && !squash;
    assign fill_index = miss_addr[3 +: INDEX_BITS];

    always_comb begin
        miss_state_next = miss_state;
        case (miss_state)
            MISS_IDLE: begin
                if (any_miss) begin
                    miss_state_next = MISS_REQUEST;
                end
            end
            MISS_REQUEST: begin
                if (load_accepted) begin
                    miss_state_next = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (fill) begin
                    miss_state_next = MISS_IDLE;
                end
            end
            default: begin
                miss_state_next = MISS_IDLE;
            end
        endcase
        // squash drops the miss, its data is ignored when it shows up
        if (squash) begin
            miss_state_next = MISS_IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            miss_state <= MISS_IDLE;
            line_valid <= '0;
        end else begin
            miss_state <= miss_state_next;
            if (fill) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss_state == MISS_IDLE && any_miss) begin
            miss_addr <= first_miss_addr;
        end
        if (load_accepted) begin
            miss_tag <= mem2proc_transaction_tag;
        end
        if (fill) begin
            line_data[fill_index] <= mem2proc_data;
            line_tag[fill_index]  <= miss_addr[31 -: TAG_BITS];
        end
    end

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

    // bus command driven by the cache
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_command_e;

    // byte address
    typedef logic [31:0] addr_t;

    // one memory block, two instructions wide
    typedef logic [63:0] mem_block_t;

    // transaction tag, zero means nothing in flight
    typedef logic [3:0] mem_tag_t;

endpackage

/* logic/stage_fetch.sv */
`include "fetch_config.svh"

module stage_fetch (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        stall,
    input  logic                                        squash,
    input  logic                                        dcache_request,
    input  mem_pkg::mem_tag_t                           mem2proc_transaction_tag,
    input  mem_pkg::mem_block_t                         mem2proc_data,
    input  mem_pkg::mem_tag_t                           mem2proc_data_tag,
    input  fetch_pkg::rob_resolve_t  [`FETCH_WIDTH-1:0] rob_resolve,
    output mem_pkg::mem_command_e                       proc2mem_command,
    output mem_pkg::addr_t                              proc2mem_addr,
    output fetch_pkg::if_id_packet_t [`FETCH_WIDTH-1:0] if_id_packet
);

    mem_pkg::addr_t pc_start;
    mem_pkg::addr_t next_pc_start;

    fetch_pkg::pc_entry_t [`FETCH_WIDTH-1:0] target_pc;

    mem_pkg::addr_t      [`FETCH_WIDTH-1:0] icache_addr;
    logic                [`FETCH_WIDTH-1:0] icache_request;
    mem_pkg::mem_block_t [`FETCH_WIDTH-1:0] icache_data;
    logic                [`FETCH_WIDTH-1:0] icache_hit;

    logic                    redirect;
    mem_pkg::addr_t          redirect_target;
    logic [`FETCH_WIDTH-1:0] lane_valid;

    branch_predictor predictor_inst (
        .clock       (clock),
        .reset       (reset),
        .pc_start    (pc_start),
        .rob_resolve (rob_resolve),
        .target_pc   (target_pc)
    );

    icache icache_inst (
        .clock                    (clock),
        .reset                    (reset),
        .squash                   (squash),
        .dcache_request           (dcache_request),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .icache_addr              (icache_addr),
        .icache_request           (icache_request),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .icache_data              (icache_data),
        .icache_hit               (icache_hit)
    );

    // lowest mispredicted report wins
    always_comb begin
        redirect        = 1'b0;
        redirect_target = pc_start;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (rob_resolve[i].valid && !rob_resolve[i].success) begin
                redirect        = 1'b1;
                redirect_target = rob_resolve[i].resolve_target;
            end
        end
    end

    // lane addresses follow the predicted chain
    always_comb begin
        icache_addr[0] = pc_start;
        for (int i = 1; i < `FETCH_WIDTH; i++) begin
            icache_addr[i] = target_pc[i-1].pc;
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            icache_request[i] = target_pc[i].valid && !redirect;
        end
    end

    // bundle ends at the first lane without a hit
    always_comb begin
        lane_valid[0] = icache_hit[0];
        for (int i = 1; i < `FETCH_WIDTH; i++) begin
            lane_valid[i] = lane_valid[i-1] && icache_hit[i];
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if_id_packet[i].valid = lane_valid[i];
            if_id_packet[i].pc    = icache_addr[i];
            if (!lane_valid[i]) begin
                if_id_packet[i].inst = `NOP_INST;
            end else if (icache_addr[i][2]) begin
                if_id_packet[i].inst = icache_data[i][63:32];
            end else begin
                if_id_packet[i].inst = icache_data[i][31:0];
            end
            if_id_packet[i].npc            = icache_addr[i] + 32'd4;
            if_id_packet[i].predict_taken  = target_pc[i].taken;
            if_id_packet[i].predict_target = target_pc[i].pc;
        end
    end

    // stall, then redirect, then the last valid lane's prediction
    always_comb begin
        next_pc_start = pc_start;
        if (!stall) begin
            if (redirect) begin
                next_pc_start = redirect_target;
            end else begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (lane_valid[i]) begin
                        next_pc_start = target_pc[i].pc;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_start <= '0;
        end else begin
            pc_start <= next_pc_start;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the fetch unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_stage_fetch -f fetch_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_stage_fetch)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "** PASS **"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb/stage_fetch_assert.sv */
module stage_fetch_assert (
    input logic                  clock,
    input logic                  reset,
    input logic                  squash,
    input logic                  dcache_request,
    input mem_pkg::mem_command_e proc2mem_command,
    input mem_pkg::mem_tag_t     mem2proc_transaction_tag,
    input mem_pkg::mem_tag_t     mem2proc_data_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    // accepted line load whose data has not come back yet
    logic              load_in_flight;
    mem_pkg::mem_tag_t load_tag;

    always @(posedge clock) begin
        if (reset || squash) begin
            load_in_flight <= 1'b0;
        end else if (proc2mem_command == mem_pkg::MEM_LOAD
                && mem2proc_transaction_tag != '0) begin
            load_in_flight <= 1'b1;
            load_tag       <= mem2proc_transaction_tag;
        end else if (load_in_flight && mem2proc_data_tag == load_tag) begin
            load_in_flight <= 1'b0;
        end
    end

    // data cache owns the bus
    no_load_during_dcache: assert property (@(posedge clock) disable iff (reset)
        dcache_request |-> proc2mem_command != mem_pkg::MEM_LOAD)
        else $error("instruction load issued while the data cache holds the bus");

    // one miss at a time
    no_load_while_waiting: assert property (@(posedge clock) disable iff (reset)
        load_in_flight |-> proc2mem_command != mem_pkg::MEM_LOAD)
        else $error("new instruction load issued while a miss is outstanding");

    idle_after_reset: assert property (@(posedge clock)
        reset |=> proc2mem_command == mem_pkg::MEM_NONE)
        else $error("memory command not idle in the cycle after reset");

endmodule

bind icache stage_fetch_assert icache_assert_inst (
    .clock                    (clock),
    .reset                    (reset),
    .squash                   (squash),
    .dcache_request           (dcache_request),
    .proc2mem_command         (proc2mem_command),
    .mem2proc_transaction_tag (mem2proc_transaction_tag),
    .mem2proc_data_tag        (mem2proc_data_tag)
);

/* tb/tb_fetch_memory.sv */
module tb_fetch_memory (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dcache_request,
    input  mem_pkg::mem_command_e proc2mem_command,
    input  mem_pkg::addr_t        proc2mem_addr,
    output mem_pkg::mem_tag_t     mem2proc_transaction_tag,
    output mem_pkg::mem_block_t   mem2proc_data,
    output mem_pkg::mem_tag_t     mem2proc_data_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 6;

    mem_pkg::mem_tag_t next_tag = 4'd1;
    mem_pkg::mem_tag_t tag_pipe [LATENCY] = '{default: '0};
    mem_pkg::addr_t    addr_pipe [LATENCY] = '{default: '0};

    // every word holds its own byte address xor a fixed pattern
    function automatic mem_pkg::mem_block_t block_at(input mem_pkg::addr_t addr);
        mem_pkg::addr_t base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ 32'h5A5A_0000, base ^ 32'h5A5A_0000};
    endfunction

    // loads refused while the data cache has the bus
    assign mem2proc_transaction_tag =
        (proc2mem_command == mem_pkg::MEM_LOAD && !dcache_request) ? next_tag : 4'd0;
    assign mem2proc_data_tag = tag_pipe[LATENCY-1];
    assign mem2proc_data     = block_at(addr_pipe[LATENCY-1]);

    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
            for (int i = 0; i < LATENCY; i++) begin
                tag_pipe[i]  <= '0;
                addr_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0]  <= mem2proc_transaction_tag;
            addr_pipe[0] <= proc2mem_addr;
            for (int i = 1; i < LATENCY; i++) begin
                tag_pipe[i]  <= tag_pipe[i-1];
                addr_pipe[i] <= addr_pipe[i-1];
            end
            // tags run 1 to 15, zero stays reserved
            if (mem2proc_transaction_tag != 4'd0) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

endmodule

/* tb/tb_stage_fetch.sv */
`include "fetch_config.svh"

module tb_stage_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    // twice the expected test length of about 1500 cycles
    localparam int CYCLE_LIMIT = 3000;
    localparam logic [31:0] BRANCH_PC    = 32'h0000_3FF8;
    localparam logic [31:0] TRAIN_PC     = 32'h0000_0040;
    localparam logic [31:0] TRAIN_TARGET = 32'h0000_01A0;

    logic clock;
    logic reset;
    logic stall;
    logic squash;
    logic dcache_request;
    mem_pkg::mem_tag_t                           mem2proc_transaction_tag;
    mem_pkg::mem_block_t                         mem2proc_data;
    mem_pkg::mem_tag_t                           mem2proc_data_tag;
    fetch_pkg::rob_resolve_t  [`FETCH_WIDTH-1:0] rob_resolve;
    mem_pkg::mem_command_e                       proc2mem_command;
    mem_pkg::addr_t                              proc2mem_addr;
    fetch_pkg::if_id_packet_t [`FETCH_WIDTH-1:0] if_id_packet;

    integer         seed;
    int             cycle_count = 0;
    int             consumed_count = 0;
    mem_pkg::addr_t expected_pc;
    fetch_pkg::if_id_packet_t consumed_q [$];

    // model of the BTB and its counters
    logic           model_valid [`BTB_SIZE];
    logic [25:0]    model_tag [`BTB_SIZE];
    mem_pkg::addr_t model_target [`BTB_SIZE];
    int             model_count [`BTB_SIZE];

    stage_fetch stage_fetch_inst (.*);

    tb_fetch_memory memory_inst (
        .clock                    (clock),
        .reset                    (reset),
        .dcache_request           (dcache_request),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] expected_word(input mem_pkg::addr_t pc);
        return pc ^ 32'h5A5A_0000;
    endfunction

    function automatic logic model_taken(input mem_pkg::addr_t pc);
        int idx;
        idx = int'(pc[5:2]);
        return model_valid[idx] && (model_tag[idx] == pc[31:6]) && (model_count[idx] >= 2);
    endfunction

    function automatic mem_pkg::addr_t model_next_pc(input mem_pkg::addr_t pc);
        if (model_taken(pc)) begin
            return model_target[int'(pc[5:2])];
        end else begin
            return pc + 32'd4;
        end
    endfunction

    function automatic fetch_pkg::rob_resolve_t make_resolve(input mem_pkg::addr_t pc,
            input logic taken, input mem_pkg::addr_t target, input logic success);
        fetch_pkg::rob_resolve_t entry;
        entry.valid          = 1'b1;
        entry.pc             = pc;
        entry.taken          = taken;
        entry.resolve_target = target;
        entry.success        = success;
        return entry;
    endfunction

    function automatic mem_pkg::addr_t random_target(input mem_pkg::addr_t base);
        return base | (mem_pkg::addr_t'($random(seed)) & 32'h0000_1FFC);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_lane(input fetch_pkg::if_id_packet_t packet);
        check_value("if_id_packet.pc", packet.pc, expected_pc);
        check_value("if_id_packet.inst", packet.inst, expected_word(expected_pc));
        check_value("if_id_packet.npc", packet.npc, expected_pc + 32'd4);
        check_value("if_id_packet.predict_taken", 32'(packet.predict_taken),
            32'(model_taken(expected_pc)));
        check_value("if_id_packet.predict_target", packet.predict_target,
            model_next_pc(expected_pc));
        expected_pc = model_next_pc(expected_pc);
        consumed_q.push_back(packet);
        consumed_count++;
    endtask

    // saturating counter moves in lane order
    task automatic update_model();
        int idx;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (rob_resolve[i].valid) begin
                idx = int'(rob_resolve[i].pc[5:2]);
                if (rob_resolve[i].taken) begin
                    if (model_count[idx] < 3) begin
                        model_count[idx]++;
                    end
                    model_valid[idx]  = 1'b1;
                    model_tag[idx]    = rob_resolve[i].pc[31:6];
                    model_target[idx] = rob_resolve[i].resolve_target;
                end else if (model_count[idx] > 0) begin
                    model_count[idx]--;
                end
            end
        end
    endtask

    // sampled on the falling edge where outputs are stable
    always @(negedge clock) begin : compare
        logic           redirect_seen;
        mem_pkg::addr_t redirect_pc;
        if (reset) begin
            expected_pc = '0;
            for (int i = 0; i < `BTB_SIZE; i++) begin
                model_valid[i] = 1'b0;
                model_count[i] = 1;
            end
        end else begin
            redirect_seen = 1'b0;
            redirect_pc   = '0;
            for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
                if (rob_resolve[i].valid && !rob_resolve[i].success) begin
                    redirect_seen = 1'b1;
                    redirect_pc   = rob_resolve[i].resolve_target;
                end
            end
            for (int i = 1; i < `FETCH_WIDTH; i++) begin
                if (if_id_packet[i].valid) begin
                    check_value("if_id_packet.valid below a valid lane",
                        32'(if_id_packet[i-1].valid), 32'd1);
                end
            end
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (!if_id_packet[i].valid) begin
                    check_value("if_id_packet.inst on invalid lane", if_id_packet[i].inst,
                        `NOP_INST);
                end
            end
            // a line request names a whole 64-bit block
            if (proc2mem_command == mem_pkg::MEM_LOAD) begin
                check_value("proc2mem_addr[2:0]", 32'(proc2mem_addr[2:0]), 32'd0);
            end
            if (redirect_seen) begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    check_value("if_id_packet.valid on redirect", 32'(if_id_packet[i].valid), 0);
                end
                if (!stall) begin
                    expected_pc = redirect_pc;
                end
            end else if (!stall) begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (if_id_packet[i].valid) begin
                        compare_lane(if_id_packet[i]);
                    end
                end
            end
            update_model();
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic wait_consumed(input int count);
        int goal;
        goal = consumed_count + count;
        while (consumed_count < goal) begin
            @(posedge clock);
        end
    endtask

    task automatic wait_load_issued();
        @(negedge clock);
        while (proc2mem_command != mem_pkg::MEM_LOAD || dcache_request) begin
            @(negedge clock);
        end
    endtask

    // lane 1 carries a younger mispredict that must lose to lane 0
    task automatic send_redirect(input mem_pkg::addr_t target, input logic with_squash);
        @(posedge clock);
        stall          <= 1'b0;
        squash         <= with_squash;
        rob_resolve[0] <= make_resolve(BRANCH_PC, 1'b0, target, 1'b0);
        rob_resolve[1] <= make_resolve(BRANCH_PC + 32'd4, 1'b0, target + 32'h100, 1'b0);
        @(posedge clock);
        squash      <= 1'b0;
        rob_resolve <= '0;
    endtask

    task automatic train_branch(input mem_pkg::addr_t pc, input mem_pkg::addr_t target,
            input logic taken);
        @(posedge clock);
        rob_resolve[0] <= make_resolve(pc, taken, target, 1'b1);
        rob_resolve[1] <= make_resolve(pc, taken, target, 1'b1);
        @(posedge clock);
        rob_resolve <= '0;
    endtask

    initial begin
        seed           = 29;
        reset          = 1'b1;
        stall          = 1'b0;
        squash         = 1'b0;
        dcache_request = 1'b0;
        rob_resolve    = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // sequential fetch from address zero
        wait_consumed(40);

        repeat (6) begin
            send_redirect(random_target(32'h0), 1'b0);
            wait_consumed(4);
        end

        // taken training and a refetch of the branch
        train_branch(TRAIN_PC, TRAIN_TARGET, 1'b1);
        send_redirect(TRAIN_PC, 1'b0);
        consumed_q.delete();
        while (consumed_q.size() < 2) begin
            @(posedge clock);
        end
        check_value("trained branch pc", consumed_q[0].pc, TRAIN_PC);
        check_value("trained predict_taken", 32'(consumed_q[0].predict_taken), 32'd1);
        check_value("trained predict_target", consumed_q[0].predict_target, TRAIN_TARGET);
        check_value("pc after taken branch", consumed_q[1].pc, TRAIN_TARGET);

        // not-taken training drops the counter back
        train_branch(TRAIN_PC, TRAIN_TARGET, 1'b0);
        send_redirect(TRAIN_PC, 1'b0);
        consumed_q.delete();
        while (consumed_q.size() < 2) begin
            @(posedge clock);
        end
        check_value("untrained branch pc", consumed_q[0].pc, TRAIN_PC);
        check_value("untrained predict_taken", 32'(consumed_q[0].predict_taken), 32'd0);
        check_value("pc after not-taken branch", consumed_q[1].pc, TRAIN_PC + 32'd4);

        // random stall with an occasional redirect
        for (int c = 1; c <= 300; c++) begin
            if (c % 50 == 0) begin
                send_redirect(random_target(32'h0), 1'b0);
            end else begin
                @(posedge clock);
                stall <= ($random(seed) % 3) == 0;
            end
        end
        @(posedge clock);
        stall <= 1'b0;

        // long data cache windows over fresh misses
        repeat (6) begin
            send_redirect(random_target(32'h0000_2000), 1'b0);
            @(posedge clock);
            dcache_request <= 1'b1;
            repeat (20 + ($random(seed) & 15)) @(posedge clock);
            dcache_request <= 1'b0;
            wait_consumed(4);
        end

        // squash while the first target's line is in flight
        repeat (3) begin
            send_redirect(random_target(32'h0000_8000), 1'b0);
            wait_load_issued();
            send_redirect(random_target(32'h0000_C000), 1'b1);
            wait_consumed(4);
        end

        $display("** PASS **");
        $finish;
    end

endmodule
